/* compile.f */
hdl/rvCorePkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/regFile.sv
hdl/forwardUnit.sv
hdl/aluUnit.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/pipelineTop.sv
verification/tbClockGen.sv
verification/pipelineTb.sv

/* Makefile */
TOP = pipelineTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --assert --top-module $(TOP) -f compile.f -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir

/* verification/pipelineTb.sv */
// Pipeline testbench with random program, instruction memory, golden model and output checks
`timescale 1ns/1ps

module pipelineTb
    import rvCorePkg::*;
();

    localparam int progLen = 200;
    localparam int progDepth = 256;
    localparam int memWindow = 16;
    localparam int initRegs = 7;
    localparam int startTimeout = 20;
    localparam int runTimeout = progLen + 40;
    localparam int drainCycles = 10;

    typedef enum logic [2:0] {
        insAdd,
        insSub,
        insAnd,
        insOr,
        insSlt,
        insAddi,
        insLoad,
        insStore
    } insKindT;

    logic clk;
    logic rst;
    logic [xlen-1:0] instr = nopInstr;
    logic [xlen-1:0] instrAddr;
    logic regWriteEn;
    logic [regAddrWidth-1:0] regWriteAddr;
    logic [xlen-1:0] regWriteData;
    logic memWriteEn;
    logic [xlen-1:0] memAddr;
    logic [xlen-1:0] memWriteData;

    // Program image, one entry per instruction slot
    insKindT progKind [progDepth];
    logic [regAddrWidth-1:0] progRd [progDepth];
    logic [regAddrWidth-1:0] progRs1 [progDepth];
    logic [regAddrWidth-1:0] progRs2 [progDepth];
    logic [11:0] progImm [progDepth];
    logic [xlen-1:0] progWord [progDepth];

    // Expected events in program order
    logic [regAddrWidth-1:0] expWriteAddr [$];
    logic [xlen-1:0] expWriteData [$];
    logic [xlen-1:0] expStoreAddr [$];
    logic [xlen-1:0] expStoreData [$];

    logic [xlen-1:0] expFetchAddr = '0;
    int cyclesSinceReset = 0;

    tbClockGen clockGen (
        .clk (clk),
        .rst (rst)
    );

    pipelineTop DUT (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .instrAddr    (instrAddr),
        .regWriteEn   (regWriteEn),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData),
        .memWriteEn   (memWriteEn),
        .memAddr      (memAddr),
        .memWriteData (memWriteData)
    );

    task automatic abortRun();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic reportMismatch(input string sigName, input logic [xlen-1:0] actual,
                                  input logic [xlen-1:0] expected);
        $display("FAIL at %0t: %s is %h, expected %h", $time, sigName, actual, expected);
        abortRun();
    endtask

    // RV32I encodings of the kept instruction formats
    function automatic logic [xlen-1:0] encodeInstr(input insKindT kind,
                                                    input logic [regAddrWidth-1:0] rd,
                                                    input logic [regAddrWidth-1:0] rs1,
                                                    input logic [regAddrWidth-1:0] rs2,
                                                    input logic [11:0] imm);
        logic [xlen-1:0] word;
        case (kind)
            insAdd: word = {funct7Base, rs2, rs1, funct3AddSub, rd, opAluReg};
            insSub: word = {funct7Alt, rs2, rs1, funct3AddSub, rd, opAluReg};
            insAnd: word = {funct7Base, rs2, rs1, funct3And, rd, opAluReg};
            insOr: word = {funct7Base, rs2, rs1, funct3Or, rd, opAluReg};
            insSlt: word = {funct7Base, rs2, rs1, funct3Slt, rd, opAluReg};
            insAddi: word = {imm, rs1, funct3AddSub, rd, opAluImm};
            insLoad: word = {imm, rs1, funct3Word, rd, opLoad};
            default: word = {imm[11:5], rs2, rs1, funct3Word, imm[4:0], opStore};
        endcase
        return word;
    endfunction

    task automatic placeInstr(input int slot, input insKindT kind,
                              input logic [regAddrWidth-1:0] rd,
                              input logic [regAddrWidth-1:0] rs1,
                              input logic [regAddrWidth-1:0] rs2,
                              input logic [11:0] imm);
        logic [7:0] idx;
        idx = 8'(slot);
        progKind[idx] = kind;
        progRd[idx] = rd;
        progRs1[idx] = rs1;
        progRs2[idx] = rs2;
        progImm[idx] = imm;
        progWord[idx] = encodeInstr(kind, rd, rs1, rs2, imm);
    endtask

    // x0..x7, skipping the destination of a load just before
    function automatic logic [regAddrWidth-1:0] pickReg(input logic [regAddrWidth-1:0] avoid);
        logic [regAddrWidth-1:0] r;
        do begin
            r = regAddrWidth'($urandom % 8);
        end while (avoid != '0 && r == avoid);
        return r;
    endfunction

    task automatic buildProgram();
        insKindT kind;
        insKindT prevKind;
        logic [regAddrWidth-1:0] prevRd;
        logic [regAddrWidth-1:0] avoid;
        logic [regAddrWidth-1:0] rd;
        logic [regAddrWidth-1:0] rs1;
        logic [regAddrWidth-1:0] rs2;
        logic [11:0] imm;
        // Zero the data window first so early loads read defined words
        for (int w = 0; w < memWindow; w++) begin
            placeInstr(w, insStore, '0, '0, '0, {6'd0, 4'(w), 2'b00});
        end
        for (int r = 1; r <= initRegs; r++) begin
            placeInstr(memWindow + r - 1, insAddi, regAddrWidth'(r), '0, '0, 12'($urandom));
        end
        prevKind = insAddi;
        prevRd = '0;
        for (int slot = memWindow + initRegs; slot < progLen; slot++) begin
            kind = insKindT'(3'($urandom % 8));
            avoid = (prevKind == insLoad) ? prevRd : '0;
            rd = pickReg('0);
            rs1 = pickReg(avoid);
            rs2 = pickReg(avoid);
            imm = 12'($urandom);
            // Base x0 with an aligned offset in the first 16 words
            if (kind == insLoad || kind == insStore) begin
                rs1 = '0;
                imm = {6'd0, 4'($urandom % 16), 2'b00};
            end
            if (kind == insStore) begin
                rd = '0;
            end
            placeInstr(slot, kind, rd, rs1, rs2, imm);
            prevKind = kind;
            prevRd = rd;
        end
    endtask

    // In-order ISA model that queues every nonzero register write and every store
    task automatic runGoldenModel();
        logic [xlen-1:0] regs [regCount];
        logic [xlen-1:0] mem [memWindow];
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] immExt;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] value;
        logic [7:0] idx;
        regs = '{default: '0};
        mem = '{default: '0};
        for (int slot = 0; slot < progLen; slot++) begin
            idx = 8'(slot);
            a = regs[progRs1[idx]];
            b = regs[progRs2[idx]];
            immExt = {{(xlen-12){progImm[idx][11]}}, progImm[idx]};
            addr = a + immExt;
            case (progKind[idx])
                insAdd: value = a + b;
                insSub: value = a - b;
                insAnd: value = a & b;
                insOr: value = a | b;
                insSlt: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                insAddi: value = a + immExt;
                insLoad: value = mem[addr[5:2]];
                default: value = '0;
            endcase
            if (progKind[idx] == insStore) begin
                mem[addr[5:2]] = b;
                expStoreAddr.push_back(addr);
                expStoreData.push_back(b);
            end else if (progRd[idx] != '0) begin
                regs[progRd[idx]] = value;
                expWriteAddr.push_back(progRd[idx]);
                expWriteData.push_back(value);
            end
        end
    endtask

    task automatic checkRegWrite();
        if (expWriteAddr.size() == 0) begin
            $display("Unexpected register write to x%0d at %0t", regWriteAddr, $time);
            abortRun();
        end else begin
            assert (regWriteAddr === expWriteAddr[0])
                else reportMismatch("regWriteAddr", xlen'(regWriteAddr), xlen'(expWriteAddr[0]));
            assert (regWriteData === expWriteData[0])
                else reportMismatch("regWriteData", regWriteData, expWriteData[0]);
            void'(expWriteAddr.pop_front());
            void'(expWriteData.pop_front());
        end
    endtask

    task automatic checkStore();
        if (expStoreAddr.size() == 0) begin
            $display("Unexpected store to address %h at %0t", memAddr, $time);
            abortRun();
        end else begin
            assert (memAddr === expStoreAddr[0])
                else reportMismatch("memAddr", memAddr, expStoreAddr[0]);
            assert (memWriteData === expStoreData[0])
                else reportMismatch("memWriteData", memWriteData, expStoreData[0]);
            void'(expStoreAddr.pop_front());
            void'(expStoreData.pop_front());
        end
    endtask

    // Instruction memory, nops past the end of the program
    always @(negedge clk) begin
        if (instrAddr < xlen'(progLen * 4)) begin
            instr <= progWord[instrAddr[9:2]];
        end else begin
            instr <= nopInstr;
        end
    end

    // Fetch address starts at zero and steps one word per cycle
    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            expFetchAddr <= '0;
        end else begin
            expFetchAddr <= expFetchAddr + xlen'(4);
        end
    end

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            cyclesSinceReset <= 0;
        end else if (cyclesSinceReset < 2) begin
            cyclesSinceReset <= cyclesSinceReset + 1;
        end
    end

    // Outputs are sampled mid-cycle; x0 writes are nops or discarded results
    always @(negedge clk) begin
        assert (instrAddr === expFetchAddr)
            else reportMismatch("instrAddr", instrAddr, expFetchAddr);
        if (cyclesSinceReset <= 1) begin
            assert (regWriteEn === 1'b0)
                else reportMismatch("regWriteEn", xlen'(regWriteEn), '0);
            assert (memWriteEn === 1'b0)
                else reportMismatch("memWriteEn", xlen'(memWriteEn), '0);
        end else begin
            if (regWriteEn === 1'b1 && regWriteAddr != '0) begin
                checkRegWrite();
            end
            if (memWriteEn === 1'b1) begin
                checkStore();
            end
        end
    end

    initial begin
        int waitCycles;
        void'($urandom(32'h8c80));
        buildProgram();
        runGoldenModel();
        waitCycles = 0;
        while (rst !== 1'b1 && waitCycles < startTimeout) begin
            @(posedge clk);
            waitCycles++;
        end
        if (rst !== 1'b1) begin
            $display("Reset was not released within %0d cycles", startTimeout);
            abortRun();
        end else begin
            waitCycles = 0;
            while ((expWriteAddr.size() != 0 || expStoreAddr.size() != 0)
                   && waitCycles < runTimeout) begin
                @(posedge clk);
                waitCycles++;
            end
            if (expWriteAddr.size() != 0 || expStoreAddr.size() != 0) begin
                $display("Timed out with %0d register writes and %0d stores still expected",
                         expWriteAddr.size(), expStoreAddr.size());
                abortRun();
            end else begin
                // Trailing nops must not add writes or stores
                for (int n = 0; n < drainCycles; n++) begin
                    @(posedge clk);
                end
                $display("All tests passed");
                $finish;
            end
        end
    end

endmodule

/* verification/tbClockGen.sv */
// Testbench clock and active-low reset generator
`timescale 1ns/1ps

module tbClockGen (
    output logic clk,
    output logic rst
);

    localparam int halfPeriod = 4;
    localparam int resetCycles = 3;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

    // Release lands on a falling edge, same as the other inputs
    initial begin
        rst = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

/* hdl/pipelineTop.sv */
// Five-stage RV32I core top with external instruction fetch and observation ports
`timescale 1ns/1ps

module pipelineTop
    import rvCorePkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [xlen-1:0]         instr,
    output logic [xlen-1:0]         instrAddr,
    output logic                    regWriteEn,
    output logic [regAddrWidth-1:0] regWriteAddr,
    output logic [xlen-1:0]         regWriteData,
    output logic                    memWriteEn,
    output logic [xlen-1:0]         memAddr,
    output logic [xlen-1:0]         memWriteData
);

    logic [xlen-1:0] instrD;
    logic regWriteE;
    logic memWriteE;
    logic aluSrcE;
    logic resultSrcE;
    aluOpT aluOpE;
    logic [xlen-1:0] immE;
    logic [regAddrWidth-1:0] rdE;
    logic [regAddrWidth-1:0] rs1E;
    logic [regAddrWidth-1:0] rs2E;
    logic [xlen-1:0] rdData1D;
    logic [xlen-1:0] rdData2D;
    fwdSelT fwdA;
    fwdSelT fwdB;
    logic regWriteM;
    logic memWriteM;
    logic resultSrcM;
    logic [regAddrWidth-1:0] rdM;
    logic [xlen-1:0] aluResultM;
    logic [xlen-1:0] writeDataM;
    logic regWriteW;
    logic [regAddrWidth-1:0] rdW;
    logic [xlen-1:0] resultW;

    // PC+4 has no consumer without jumps
    fetchStage fetchInst (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .instrAddr (instrAddr),
        .instrD    (instrD),
        .pcPlus4D  ()
    );

    decodeStage decodeInst (
        .clk        (clk),
        .rst        (rst),
        .instrD     (instrD),
        .regWriteE  (regWriteE),
        .memWriteE  (memWriteE),
        .aluSrcE    (aluSrcE),
        .resultSrcE (resultSrcE),
        .aluOpE     (aluOpE),
        .immE       (immE),
        .rdE        (rdE),
        .rs1E       (rs1E),
        .rs2E       (rs2E)
    );

    regFile regFileInst (
        .clk       (clk),
        .rst       (rst),
        .rs1       (instrD[rs1Msb:rs1Lsb]),
        .rs2       (instrD[rs2Msb:rs2Lsb]),
        .writeAddr (rdW),
        .writeEn   (regWriteW),
        .writeData (resultW),
        .rdData1   (rdData1D),
        .rdData2   (rdData2D)
    );

    forwardUnit forwardInst (
        .rs1E      (rs1E),
        .rs2E      (rs2E),
        .rdM       (rdM),
        .regWriteM (regWriteM),
        .rdW       (rdW),
        .regWriteW (regWriteW),
        .fwdA      (fwdA),
        .fwdB      (fwdB)
    );

    executeStage executeInst (
        .clk        (clk),
        .rst        (rst),
        .regWriteE  (regWriteE),
        .memWriteE  (memWriteE),
        .aluSrcE    (aluSrcE),
        .resultSrcE (resultSrcE),
        .aluOpE     (aluOpE),
        .immE       (immE),
        .rdE        (rdE),
        .rdData1D   (rdData1D),
        .rdData2D   (rdData2D),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .resultW    (resultW),
        .regWriteM  (regWriteM),
        .memWriteM  (memWriteM),
        .resultSrcM (resultSrcM),
        .rdM        (rdM),
        .aluResultM (aluResultM),
        .writeDataM (writeDataM)
    );

    memoryStage memoryInst (
        .clk        (clk),
        .rst        (rst),
        .regWriteM  (regWriteM),
        .memWriteM  (memWriteM),
        .resultSrcM (resultSrcM),
        .rdM        (rdM),
        .aluResultM (aluResultM),
        .writeDataM (writeDataM),
        .regWriteW  (regWriteW),
        .rdW        (rdW),
        .resultW    (resultW)
    );

    // Observation ports
    assign regWriteEn = regWriteW;
    assign regWriteAddr = rdW;
    assign regWriteData = resultW;
    assign memWriteEn = memWriteM;
    assign memAddr = aluResultM;
    assign memWriteData = writeDataM;

endmodule

/* hdl/memoryStage.sv */
// Data memory, memory-to-writeback register and writeback result select
`timescale 1ns/1ps

module memoryStage
    import rvCorePkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    regWriteM,
    input  logic                    memWriteM,
    input  logic                    resultSrcM,
    input  logic [regAddrWidth-1:0] rdM,
    input  logic [xlen-1:0]         aluResultM,
    input  logic [xlen-1:0]         writeDataM,
    output logic                    regWriteW,
    output logic [regAddrWidth-1:0] rdW,
    output logic [xlen-1:0]         resultW
);

    logic [xlen-1:0] dmem [dmemWords];
    logic [dmemAddrWidth-1:0] wordAddr;
    logic [xlen-1:0] readDataM;
    logic resultSrcW;
    logic [xlen-1:0] aluResultW;
    logic [xlen-1:0] readDataW;

    assign wordAddr = aluResultM[dmemAddrWidth+wordOffsetBits-1:wordOffsetBits];
    assign readDataM = dmem[wordAddr];

    always_ff @(posedge clk) begin
        if (memWriteM) begin
            dmem[wordAddr] <= writeDataM;
        end
        aluResultW <= aluResultM;
        readDataW <= readDataM;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regWriteW <= 1'b0;
            resultSrcW <= 1'b0;
            rdW <= '0;
        end else begin
            regWriteW <= regWriteM;
            resultSrcW <= resultSrcM;
            rdW <= rdM;
        end
    end

    assign resultW = resultSrcW ? readDataW : aluResultW;

    storeAligned: assert property (@(posedge clk) disable iff (!rst)
        memWriteM |-> aluResultM[wordOffsetBits-1:0] == '0);

endmodule

/* hdl/executeStage.sv */
// Operand forwarding, immediate select, ALU and the execute-to-memory register
`timescale 1ns/1ps

module executeStage
    import rvCorePkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    regWriteE,
    input  logic                    memWriteE,
    input  logic                    aluSrcE,
    input  logic                    resultSrcE,
    input  aluOpT                   aluOpE,
    input  logic [xlen-1:0]         immE,
    input  logic [regAddrWidth-1:0] rdE,
    input  logic [xlen-1:0]         rdData1D,
    input  logic [xlen-1:0]         rdData2D,
    input  fwdSelT                  fwdA,
    input  fwdSelT                  fwdB,
    input  logic [xlen-1:0]         resultW,
    output logic                    regWriteM,
    output logic                    memWriteM,
    output logic                    resultSrcM,
    output logic [regAddrWidth-1:0] rdM,
    output logic [xlen-1:0]         aluResultM,
    output logic [xlen-1:0]         writeDataM
);

    logic [xlen-1:0] rdData1E;
    logic [xlen-1:0] rdData2E;
    logic [xlen-1:0] srcA;
    logic [xlen-1:0] fwdDataB;
    logic [xlen-1:0] srcB;
    logic [xlen-1:0] aluResult;

    function automatic logic [xlen-1:0] pickOperand(input fwdSelT sel,
                                                    input logic [xlen-1:0] regVal);
        logic [xlen-1:0] value;
        case (sel)
            fwdMemory: value = aluResultM;
            fwdWriteback: value = resultW;
            default: value = regVal;
        endcase
        return value;
    endfunction

    // Register read data enters execute alongside the decoded controls
    always_ff @(posedge clk) begin
        rdData1E <= rdData1D;
        rdData2E <= rdData2D;
    end

    always_comb begin
        srcA = pickOperand(fwdA, rdData1E);
        fwdDataB = pickOperand(fwdB, rdData2E);
        srcB = aluSrcE ? immE : fwdDataB;
    end

    aluUnit aluInst (
        .srcA   (srcA),
        .srcB   (srcB),
        .aluOp  (aluOpE),
        .result (aluResult)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regWriteM <= 1'b0;
            memWriteM <= 1'b0;
            resultSrcM <= 1'b0;
            rdM <= '0;
        end else begin
            regWriteM <= regWriteE;
            memWriteM <= memWriteE;
            resultSrcM <= resultSrcE;
            rdM <= rdE;
        end
    end

    // Store data takes the forwarded rs2, not the immediate
    always_ff @(posedge clk) begin
        aluResultM <= aluResult;
        writeDataM <= fwdDataB;
    end

endmodule

/* hdl/aluUnit.sv */
// ALU for add, sub, and, or and signed set-less-than
`timescale 1ns/1ps

module aluUnit
    import rvCorePkg::*;
(
    input  logic [xlen-1:0] srcA,
    input  logic [xlen-1:0] srcB,
    input  aluOpT           aluOp,
    output logic [xlen-1:0] result
);

    logic subtract;
    logic [xlen-1:0] operandB;
    logic [xlen-1:0] sum;
    logic overflow;

    // One adder serves add, sub and the slt compare
    assign subtract = (aluOp == aluSub) || (aluOp == aluSlt);
    assign operandB = subtract ? ~srcB : srcB;
    assign sum = srcA + operandB + xlen'(subtract);

    // Same-signed inputs giving a differently signed sum
    assign overflow = (srcA[xlen-1] == operandB[xlen-1]) && (sum[xlen-1] != srcA[xlen-1]);

    always_comb begin
        case (aluOp)
            aluAdd, aluSub: result = sum;
            aluAnd: result = srcA & srcB;
            aluOr: result = srcA | srcB;
            aluSlt: result = {{(xlen-1){1'b0}}, sum[xlen-1] ^ overflow};
            default: result = '0;
        endcase
    end

endmodule

/* hdl/forwardUnit.sv */
// Forwarding source select for both execute operands
`timescale 1ns/1ps

module forwardUnit
    import rvCorePkg::*;
(
    input  logic [regAddrWidth-1:0] rs1E,
    input  logic [regAddrWidth-1:0] rs2E,
    input  logic [regAddrWidth-1:0] rdM,
    input  logic                    regWriteM,
    input  logic [regAddrWidth-1:0] rdW,
    input  logic                    regWriteW,
    output fwdSelT                  fwdA,
    output fwdSelT                  fwdB
);

    // Memory stage holds the younger value, so it wins
    function automatic fwdSelT pickSource(input logic [regAddrWidth-1:0] rs);
        fwdSelT sel;
        if (regWriteM && rdM != '0 && rdM == rs) begin
            sel = fwdMemory;
        end else if (regWriteW && rdW != '0 && rdW == rs) begin
            sel = fwdWriteback;
        end else begin
            sel = fwdNone;
        end
        return sel;
    endfunction

    always_comb begin
        fwdA = pickSource(rs1E);
        fwdB = pickSource(rs2E);
    end

    // A forwarded operand must name a live nonzero destination
    always_comb begin
        assert (fwdA == fwdNone || (fwdA == fwdMemory ? rdM : rdW) == rs1E && rs1E != '0);
        assert (fwdB == fwdNone || (fwdB == fwdMemory ? rdM : rdW) == rs2E && rs2E != '0);
    end

endmodule

/* hdl/regFile.sv */
// 32-entry integer register file with x0 tied to zero
`timescale 1ns/1ps

module regFile
    import rvCorePkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [regAddrWidth-1:0] rs1,
    input  logic [regAddrWidth-1:0] rs2,
    input  logic [regAddrWidth-1:0] writeAddr,
    input  logic                    writeEn,
    input  logic [xlen-1:0]         writeData,
    output logic [xlen-1:0]         rdData1,
    output logic [xlen-1:0]         rdData2
);

    logic [xlen-1:0] regs [regCount];

    // Write-through keeps a reader three slots behind the writer current
    function automatic logic [xlen-1:0] readPort(input logic [regAddrWidth-1:0] addr);
        logic [xlen-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (writeEn && addr == writeAddr) begin
            value = writeData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rdData1 = rst ? readPort(rs1) : '0;
        rdData2 = rst ? readPort(rs2) : '0;
    end

    always_ff @(posedge clk) begin
        if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

/* hdl/decodeStage.sv */
// Control decode, immediate extension and the decode-to-execute register
`timescale 1ns/1ps

module decodeStage
    import rvCorePkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [xlen-1:0]         instrD,
    output logic                    regWriteE,
    output logic                    memWriteE,
    output logic                    aluSrcE,
    output logic                    resultSrcE,
    output aluOpT                   aluOpE,
    output logic [xlen-1:0]         immE,
    output logic [regAddrWidth-1:0] rdE,
    output logic [regAddrWidth-1:0] rs1E,
    output logic [regAddrWidth-1:0] rs2E
);

    opcodeT opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic regWriteD;
    logic memWriteD;
    logic aluSrcD;
    logic resultSrcD;
    aluOpT aluOpD;
    logic [xlen-1:0] immD;

    assign opcode = opcodeT'(instrD[opcodeMsb:opcodeLsb]);
    assign funct3 = instrD[funct3Msb:funct3Lsb];
    assign funct7 = instrD[funct7Msb:funct7Lsb];

    // Main control
    always_comb begin
        regWriteD = 1'b0;
        memWriteD = 1'b0;
        aluSrcD = 1'b0;
        resultSrcD = 1'b0;
        case (opcode)
            opLoad: begin
                regWriteD = 1'b1;
                aluSrcD = 1'b1;
                resultSrcD = 1'b1;
            end
            opStore: begin
                memWriteD = 1'b1;
                aluSrcD = 1'b1;
            end
            opAluImm: begin
                regWriteD = 1'b1;
                aluSrcD = 1'b1;
            end
            opAluReg: regWriteD = 1'b1;
            default: regWriteD = 1'b0;
        endcase
    end

    // Loads, stores and immediates all add
    always_comb begin
        aluOpD = aluAdd;
        if (opcode == opAluReg) begin
            case (funct3)
                funct3AddSub: aluOpD = (funct7 == funct7Alt) ? aluSub : aluAdd;
                funct3Slt: aluOpD = aluSlt;
                funct3Or: aluOpD = aluOr;
                funct3And: aluOpD = aluAnd;
                default: aluOpD = aluAdd;
            endcase
        end
    end

    // S-type splits the immediate around rd
    assign immD = (opcode == opStore)
        ? {{(xlen-12){instrD[xlen-1]}}, funct7, instrD[rdMsb:rdLsb]}
        : {{(xlen-12){instrD[xlen-1]}}, instrD[xlen-1:rs2Lsb]};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            aluSrcE <= 1'b0;
            resultSrcE <= 1'b0;
            aluOpE <= aluAdd;
            rdE <= '0;
            rs1E <= '0;
            rs2E <= '0;
        end else begin
            regWriteE <= regWriteD;
            memWriteE <= memWriteD;
            aluSrcE <= aluSrcD;
            resultSrcE <= resultSrcD;
            aluOpE <= aluOpD;
            rdE <= instrD[rdMsb:rdLsb];
            rs1E <= instrD[rs1Msb:rs1Lsb];
            rs2E <= instrD[rs2Msb:rs2Lsb];
        end
    end

    always_ff @(posedge clk) begin
        immE <= immD;
    end

    aluOpLegal: assert property (@(posedge clk) disable iff (!rst)
        aluOpE inside {aluAdd, aluSub, aluAnd, aluOr, aluSlt});

endmodule

/* hdl/fetchStage.sv */
// Program counter and the fetch-to-decode pipeline register
`timescale 1ns/1ps

module fetchStage
    import rvCorePkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] instr,
    output logic [xlen-1:0] instrAddr,
    output logic [xlen-1:0] instrD,
    output logic [xlen-1:0] pcPlus4D
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pcPlus4;

    assign pcPlus4 = pc + xlen'(4);
    assign instrAddr = pc;

    // No branches, so the PC only ever steps forward
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= '0;
            instrD <= nopInstr;
        end else begin
            pc <= pcPlus4;
            instrD <= instr;
        end
    end

    always_ff @(posedge clk) begin
        pcPlus4D <= pcPlus4;
    end

endmodule

/* hdl/rvCorePkg.sv */
// Core widths, instruction field positions, funct encodings, nop word and shared enums
package rvCorePkg;

    localparam int xlen = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount = 2 ** regAddrWidth;

    // Data memory, addressed by word index
    localparam int dmemWords = 1024;
    localparam int dmemAddrWidth = $clog2(dmemWords);
    localparam int wordOffsetBits = 2;

    // Instruction field positions
    localparam int opcodeLsb = 0;
    localparam int opcodeMsb = 6;
    localparam int rdLsb = 7;
    localparam int rdMsb = 11;
    localparam int funct3Lsb = 12;
    localparam int funct3Msb = 14;
    localparam int rs1Lsb = 15;
    localparam int rs1Msb = 19;
    localparam int rs2Lsb = 20;
    localparam int rs2Msb = 24;
    localparam int funct7Lsb = 25;
    localparam int funct7Msb = 31;

    // funct3 values of the kept operations
    localparam logic [2:0] funct3AddSub = 3'b000;
    localparam logic [2:0] funct3Slt = 3'b010;
    localparam logic [2:0] funct3Or = 3'b110;
    localparam logic [2:0] funct3And = 3'b111;
    localparam logic [2:0] funct3Word = 3'b010;

    localparam logic [6:0] funct7Base = 7'b0000000;
    localparam logic [6:0] funct7Alt = 7'b0100000;

    // addi x0,x0,0
    localparam logic [xlen-1:0] nopInstr = 32'h0000_0013;

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opAluImm = 7'b0010011,
        opAluReg = 7'b0110011
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    typedef enum logic [1:0] {
        fwdNone,
        fwdWriteback,
        fwdMemory
    } fwdSelT;

endpackage
